// ==== hw/alu.sv ====
`timescale 1ns/100ps
`include "legv8_defs.svh"

module alu (
	input  legv8Pkg::aluOpKind     aluOp,
	input  logic [10:0]            opcode,
	input  logic [`LEGV8_XLEN-1:0] a,
	input  logic [`LEGV8_XLEN-1:0] b,
	output logic [`LEGV8_XLEN-1:0] result,
	output logic                   zero
);
	import legv8Pkg::*;

	aluSel sel;

	always_comb begin
		case (aluOp)
			aopAddr: sel = aluAdd;
			aopPassB: sel = aluPassB;
			default: begin
				if (opcode == `OPC_SUB)
					sel = aluSub;
				else if (opcode == `OPC_AND)
					sel = aluAnd;
				else if (opcode == `OPC_ORR)
					sel = aluOrr;
				else
					sel = aluAdd; // ADD and ADDI
			end
		endcase
	end

	always_comb begin
		case (sel)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOrr: result = a | b;
			default: result = b; // CB test value
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== hw/cpuControl.sv ====
`timescale 1ns/100ps
`include "legv8_defs.svh"

module cpuControl (
	input  logic [10:0]        opcode,
	output legv8Pkg::ctrlSig   ctrl,
	output legv8Pkg::instClass kind,
	output logic               illegal
);
	import legv8Pkg::*;

	// First match wins, low bits of ADDI, CB and B are don't-care
	always_comb begin
		casez (opcode)
			`OPC_LDUR: kind = iLdur;
			`OPC_STUR: kind = iStur;
			`OPC_ADD: kind = iAdd;
			`OPC_SUB: kind = iSub;
			`OPC_AND: kind = iAnd;
			`OPC_ORR: kind = iOrr;
			`OPC_HALT: kind = iHalt;
			{`OPC_ADDI, 1'b?}: kind = iAddi;
			{`OPC_CBZ, 3'b???}: kind = iCbz;
			{`OPC_CBNZ, 3'b???}: kind = iCbnz;
			{`OPC_B, 5'b?????}: kind = iB;
			default: kind = iIllegal;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aopAddr;
		case (kind)
			iLdur: begin
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 2'b01; // Base plus D offset
				ctrl.regWrite = 1'b1;
			end
			iStur: begin
				ctrl.reg2Loc = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 2'b01;
			end
			iAdd, iSub, iAnd, iOrr: begin
				ctrl.aluOp = aopRType;
				ctrl.regWrite = 1'b1;
			end
			iAddi: begin
				ctrl.aluOp = aopRType;
				ctrl.aluSrc = 2'b10;
				ctrl.regWrite = 1'b1;
			end
			iCbz: begin
				ctrl.reg2Loc = 1'b1; // Test Rt
				ctrl.branchZero = 1'b1;
				ctrl.aluOp = aopPassB;
			end
			iCbnz: begin
				ctrl.reg2Loc = 1'b1;
				ctrl.branchNonZero = 1'b1;
				ctrl.aluOp = aopPassB;
			end
			iB: begin
				ctrl.branch = 1'b1;
			end
			default: begin
				// HALT and unknown opcodes leave every enable low
			end
		endcase
	end

	assign illegal = (kind == iIllegal);

	always_comb begin
		assert (!(ctrl.memRead && ctrl.memWrite))
			else $error("cpuControl: load and store decoded together, opcode %h", opcode);
	end

endmodule

// ==== hw/cpuCore.sv ====
`timescale 1ns/100ps
`include "legv8_defs.svh"

module cpuCore (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      imemWe,
	input  logic [`LEGV8_IMEM_AW-1:0] imemAddr,
	input  logic [31:0]               imemData,
	output logic                      halted,
	output logic                      illegalOp,
	output logic [`LEGV8_XLEN-1:0]    pc,
	output legv8Pkg::storeBeat        store
);
	import legv8Pkg::*;

	logic [31:0] imem [0:`LEGV8_IMEM_DEPTH-1];
	logic [31:0] inst;

	ctrlSig   ctrl;
	instClass kind;
	logic     illegal;

	logic [4:0]             rAddrB;
	logic [`LEGV8_XLEN-1:0] rDataA;
	logic [`LEGV8_XLEN-1:0] rDataB;
	logic [`LEGV8_XLEN-1:0] dOffset;
	logic [`LEGV8_XLEN-1:0] imm12;
	logic [`LEGV8_XLEN-1:0] aluB;
	logic [`LEGV8_XLEN-1:0] aluResult;
	logic [`LEGV8_XLEN-1:0] memRData;
	logic [`LEGV8_XLEN-1:0] wbData;
	logic [`LEGV8_XLEN-1:0] brOffset;
	logic [`LEGV8_XLEN-1:0] nextPc;
	logic [`LEGV8_DMEM_AW-1:0] dmemAddr;
	logic zero;
	logic takeBranch;
	logic active;
	logic stopNow;

	// Program load port, only open during reset
	always_ff @(posedge clk) begin
		if (rst && imemWe)
			imem[imemAddr] <= imemData;
	end

	assign inst = imem[pc[`LEGV8_IMEM_AW+1:2]];

	cpuControl control (
		.opcode (inst[31:21]),
		.ctrl   (ctrl),
		.kind   (kind),
		.illegal(illegal)
	);

	assign rAddrB = ctrl.reg2Loc ? inst[4:0] : inst[20:16];

	regFile regs (
		.clk   (clk),
		.we    (ctrl.regWrite && active),
		.rAddrA(inst[9:5]),
		.rAddrB(rAddrB),
		.wAddr (inst[4:0]),
		.wData (wbData),
		.rDataA(rDataA),
		.rDataB(rDataB)
	);

	assign dOffset = {{(`LEGV8_XLEN-9){inst[20]}}, inst[20:12]};
	assign imm12 = {{(`LEGV8_XLEN-12){1'b0}}, inst[21:10]};

	always_comb begin
		case (ctrl.aluSrc)
			2'b01: aluB = dOffset;
			2'b10: aluB = imm12;
			default: aluB = rDataB;
		endcase
	end

	alu exec (
		.aluOp (ctrl.aluOp),
		.opcode(inst[31:21]),
		.a     (rDataA),
		.b     (aluB),
		.result(aluResult),
		.zero  (zero)
	);

	assign dmemAddr = aluResult[`LEGV8_DMEM_AW+2:3]; // Byte to doubleword

	dataMem dmem (
		.clk  (clk),
		.we   (ctrl.memWrite && active),
		.addr (dmemAddr),
		.wData(rDataB),
		.rData(memRData)
	);

	assign wbData = ctrl.memToReg ? memRData : aluResult;

	// B carries 26 offset bits, CB carries 19
	assign brOffset = ctrl.branch ? {{(`LEGV8_XLEN-26){inst[25]}}, inst[25:0]}
		: {{(`LEGV8_XLEN-19){inst[23]}}, inst[23:5]};
	assign takeBranch = ctrl.branch || (ctrl.branchZero && zero)
		|| (ctrl.branchNonZero && !zero);
	assign nextPc = takeBranch ? pc + (brOffset << 2) : pc + 64'd4;

	assign active = !rst && !halted;
	assign stopNow = (kind == iHalt) || illegal;

	assign store.valid = ctrl.memWrite && active;
	assign store.addr = dmemAddr;
	assign store.data = rDataB;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			halted <= 1'b0;
			illegalOp <= 1'b0;
		end else if (!halted) begin
			if (stopNow) begin
				halted <= 1'b1; // PC stays on the stopping word
				illegalOp <= illegal;
			end else begin
				pc <= nextPc;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		!halted |-> pc < 4 * `LEGV8_IMEM_DEPTH)
		else $error("cpuCore: pc %h left instruction memory", pc);

	// Data accesses must be doubleword aligned
	assert property (@(posedge clk) disable iff (rst)
		active && (ctrl.memRead || ctrl.memWrite) |-> aluResult[2:0] == 3'b000)
		else $error("cpuCore: unaligned data address %h", aluResult);

endmodule

// ==== hw/dataMem.sv ====
`timescale 1ns/100ps
`include "legv8_defs.svh"

module dataMem (
	input  logic                      clk,
	input  logic                      we,
	input  logic [`LEGV8_DMEM_AW-1:0] addr,
	input  logic [`LEGV8_XLEN-1:0]    wData,
	output logic [`LEGV8_XLEN-1:0]    rData
);

	logic [`LEGV8_XLEN-1:0] mem [0:`LEGV8_DMEM_DEPTH-1];

	// Start from a known all-zero image
	initial begin
		for (int i = 0; i < `LEGV8_DMEM_DEPTH; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wData;
	end

	assign rData = mem[addr];

endmodule

// ==== hw/legv8Pkg.sv ====
`include "legv8_defs.svh"

package legv8Pkg;

	typedef enum logic [3:0] {
		iLdur,
		iStur,
		iAdd,
		iSub,
		iAnd,
		iOrr,
		iAddi,
		iCbz,
		iCbnz,
		iB,
		iHalt,
		iIllegal
	} instClass;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOrr,
		aluPassB
	} aluSel;

	typedef enum logic [1:0] {
		aopAddr  = 2'b00,
		aopPassB = 2'b01,
		aopRType = 2'b10
	} aluOpKind;

	typedef struct packed {
		logic       reg2Loc;       // Port B reads Rt instead of Rm
		logic       branch;
		logic       branchZero;
		logic       branchNonZero;
		logic       memRead;
		logic       memToReg;
		logic       memWrite;
		logic       regWrite;
		logic [1:0] aluSrc;        // 00 reg, 01 D offset, 10 imm12
		aluOpKind   aluOp;
	} ctrlSig;

	typedef struct packed {
		logic                      valid;
		logic [`LEGV8_DMEM_AW-1:0] addr; // Doubleword index
		logic [`LEGV8_XLEN-1:0]    data;
	} storeBeat;

endpackage

// ==== hw/legv8_defs.svh ====
`ifndef LEGV8_DEFS_SVH
`define LEGV8_DEFS_SVH

`define LEGV8_XLEN       64
`define LEGV8_REGS       32
`define LEGV8_IMEM_DEPTH 256
`define LEGV8_IMEM_AW    8
`define LEGV8_DMEM_DEPTH 256
`define LEGV8_DMEM_AW    8

// Full 11-bit opcode field
`define OPC_LDUR 11'b11111000010
`define OPC_STUR 11'b11111000000
`define OPC_ADD  11'b10001011000
`define OPC_SUB  11'b11001011000
`define OPC_AND  11'b10001010000
`define OPC_ORR  11'b10101010000
`define OPC_HALT 11'b11111111111

`define OPC_ADDI 10'b1001000100 // Bits 31:22
`define OPC_CBZ  8'b10110100    // Bits 31:24
`define OPC_CBNZ 8'b10110101
`define OPC_B    6'b000101      // Bits 31:26

`endif

// ==== hw/regFile.sv ====
`timescale 1ns/100ps
`include "legv8_defs.svh"

module regFile (
	input  logic                   clk,
	input  logic                   we,
	input  logic [4:0]             rAddrA,
	input  logic [4:0]             rAddrB,
	input  logic [4:0]             wAddr,
	input  logic [`LEGV8_XLEN-1:0] wData,
	output logic [`LEGV8_XLEN-1:0] rDataA,
	output logic [`LEGV8_XLEN-1:0] rDataB
);

	logic [`LEGV8_XLEN-1:0] regs [0:`LEGV8_REGS-1];

	always_ff @(posedge clk) begin
		if (we && wAddr != 5'd31)
			regs[wAddr] <= wData; // XZR writes vanish
	end

	assign rDataA = (rAddrA == 5'd31) ? '0 : regs[rAddrA];
	assign rDataB = (rAddrB == 5'd31) ? '0 : regs[rAddrB];

	// A write aimed at XZR leaves its storage untouched
	assert property (@(posedge clk)
		we && wAddr == 5'd31 |=> $stable(regs[5'd31]))
		else $error("regFile: write to X31 was accepted");

endmodule

// ==== list.f ====
+incdir+hw
hw/legv8Pkg.sv
hw/cpuControl.sv
hw/alu.sv
hw/regFile.sv
hw/dataMem.sv
hw/cpuCore.sv
verif/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the cpuCore testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module cpuCoreTb -f list.f -o cpuCoreSim \
	> build.log 2>&1 \
	&& ./obj_dir/cpuCoreSim > sim.log 2>&1 \
	; cat sim.log 2>/dev/null \
	; grep -q "^TEST OK$" sim.log && echo "PASS" \
	|| { echo "FAIL (see build.log and sim.log)"; exit 1; }

// ==== verif/cpuCoreTb.sv ====
`timescale 1ns/100ps
`include "legv8_defs.svh"

module cpuCoreTb;
	import legv8Pkg::*;

	typedef enum logic [2:0] {opAdd, opSub, opAnd, opOrr, opAddi} rowOp;

	typedef struct packed {
		rowOp        op;
		logic [11:0] a;
		logic [11:0] b;
		logic [7:0]  slot;   // Doubleword index of the STUR
		logic [63:0] result;
	} stimRow;

	localparam int NumRows = 6;
	localparam int RunLimit = 200; // Cycles per run before giving up

	logic        clk;
	logic        rst;
	logic        imemWe;
	logic [7:0]  imemAddr;
	logic [31:0] imemData;
	logic        halted;
	logic        illegalOp;
	logic [63:0] pc;
	storeBeat    store;

	stimRow      stim [NumRows];
	logic [31:0] prog [$];
	storeBeat    expStores [$];
	storeBeat    gotStores [$];
	logic [31:0] rng;
	int          valueErrors;
	int          otherErrors;

	cpuCore uut (
		.clk      (clk),
		.rst      (rst),
		.imemWe   (imemWe),
		.imemAddr (imemAddr),
		.imemData (imemData),
		.halted   (halted),
		.illegalOp(illegalOp),
		.pc       (pc),
		.store    (store)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// 64-bit wraparound on zero-extended 12-bit operands
	function automatic logic [63:0] expectedResult(rowOp op, logic [11:0] a, logic [11:0] b);
		logic [63:0] x;
		logic [63:0] y;
		x = {52'd0, a};
		y = {52'd0, b};
		case (op)
			opSub: return x - y;
			opAnd: return x & y;
			opOrr: return x | y;
			default: return x + y;
		endcase
	endfunction

	function automatic logic [10:0] opcodeOf(rowOp op);
		case (op)
			opSub: return `OPC_SUB;
			opAnd: return `OPC_AND;
			opOrr: return `OPC_ORR;
			default: return `OPC_ADD;
		endcase
	endfunction

	function automatic logic [31:0] encR(logic [10:0] opc, logic [4:0] rm, logic [4:0] rn,
		logic [4:0] rd);
		return {opc, rm, 6'd0, rn, rd};
	endfunction

	function automatic logic [31:0] encAddi(logic [11:0] imm, logic [4:0] rn, logic [4:0] rd);
		return {`OPC_ADDI, imm, rn, rd};
	endfunction

	function automatic logic [31:0] encD(logic [10:0] opc, logic [8:0] off, logic [4:0] rn,
		logic [4:0] rt);
		return {opc, off, 2'b00, rn, rt};
	endfunction

	function automatic logic [31:0] encCb(logic [7:0] opc, logic [18:0] off, logic [4:0] rt);
		return {opc, off, rt};
	endfunction

	function automatic logic [31:0] encB(logic [25:0] off);
		return {`OPC_B, off};
	endfunction

	task automatic checkValue(string name, logic [63:0] got, logic [63:0] want);
		assert (got == want) else begin
			$display("[ERROR] %s: got %h, expected %h", name, got, want);
			valueErrors++;
		end
	endtask

	// STUR Rt to [X31 + slot*8], and note the beat it must produce
	task automatic emitStore(logic [4:0] rt, logic [7:0] slot, logic [63:0] value);
		prog.push_back(encD(`OPC_STUR, {slot[5:0], 3'b000}, 5'd31, rt));
		expStores.push_back({1'b1, slot, value});
	endtask

	task automatic fillTable();
		rowOp ops [NumRows] = '{opAdd, opSub, opAnd, opOrr, opAddi, opSub};
		foreach (stim[i]) begin
			stim[i].op = ops[i];
			rng = xorshift32(rng);
			stim[i].a = rng[11:0];
			rng = xorshift32(rng);
			stim[i].b = rng[11:0];
			stim[i].slot = 8'(i);
			stim[i].result = expectedResult(ops[i], stim[i].a, stim[i].b);
		end
	endtask

	task automatic buildProgram();
		logic [11:0] c;
		foreach (stim[i]) begin
			prog.push_back(encAddi(stim[i].a, 5'd31, 5'd1));
			prog.push_back(encAddi(stim[i].b, 5'd31, 5'd2));
			if (stim[i].op == opAddi)
				prog.push_back(encAddi(stim[i].b, 5'd1, 5'd3));
			else
				prog.push_back(encR(opcodeOf(stim[i].op), 5'd2, 5'd1, 5'd3));
			emitStore(5'd3, stim[i].slot, stim[i].result);
		end
		rng = xorshift32(rng);
		c = rng[11:0];
		prog.push_back(encAddi(c, 5'd31, 5'd4));
		emitStore(5'd4, 8'd10, {52'd0, c});
		prog.push_back(encD(`OPC_LDUR, 9'd80, 5'd31, 5'd5)); // Read back slot 10
		prog.push_back(encAddi(12'd1, 5'd5, 5'd6));
		emitStore(5'd6, 8'd11, {52'd0, c} + 64'd1);
		prog.push_back(encAddi(12'd5, 5'd31, 5'd7));
		prog.push_back(encCb(`OPC_CBZ, 19'd2, 5'd31));        // Taken
		prog.push_back(encD(`OPC_STUR, 9'd96, 5'd31, 5'd7));
		prog.push_back(encCb(`OPC_CBNZ, 19'd2, 5'd7));        // Taken
		prog.push_back(encD(`OPC_STUR, 9'd104, 5'd31, 5'd7));
		prog.push_back(encCb(`OPC_CBZ, 19'd2, 5'd7));         // Falls through
		emitStore(5'd7, 8'd14, 64'd5);
		prog.push_back(encB(26'd2));
		prog.push_back(encD(`OPC_STUR, 9'd120, 5'd31, 5'd7)); // Jumped over
		prog.push_back(encR(`OPC_ADD, 5'd7, 5'd7, 5'd31));
		emitStore(5'd31, 8'd16, 64'd0);
		prog.push_back({`OPC_HALT, 21'd0});
	endtask

	task automatic loadProgram();
		@(posedge clk);
		rst <= 1'b1;
		foreach (prog[i]) begin
			imemWe <= 1'b1;
			imemAddr <= 8'(i);
			imemData <= prog[i];
			@(posedge clk);
		end
		imemWe <= 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic runUntilHalt();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			if (store.valid)
				gotStores.push_back(store);
			cycles++;
		end while (!halted && cycles < RunLimit);
		assert (halted) else begin
			$display("Timeout: halted did not rise within %0d cycles", RunLimit);
			otherErrors++;
		end
	endtask

	task automatic compareStores();
		assert (gotStores.size() == expStores.size()) else begin
			$display("The core made %0d stores where the program should make %0d",
				gotStores.size(), expStores.size());
			otherErrors++;
		end
		foreach (expStores[i]) begin
			if (i < gotStores.size()) begin
				checkValue("store.addr", 64'(gotStores[i].addr), 64'(expStores[i].addr));
				checkValue("store.data", gotStores[i].data, expStores[i].data);
			end
		end
		foreach (gotStores[i]) begin
			assert (gotStores[i].addr != 8'd15) else begin
				$display("A store reached slot 15, which the B should have jumped over");
				otherErrors++;
			end
		end
	endtask

	initial begin
		logic [63:0] holdPc;
		clk = 1'b0;
		rst = 1'b1;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		valueErrors = 0;
		otherErrors = 0;
		rng = 32'hd4a34e6e;
		fillTable();
		buildProgram();
		loadProgram();
		runUntilHalt();
		compareStores();
		checkValue("illegalOp", 64'(illegalOp), 64'd0);
		checkValue("pc", pc, 64'(4 * (prog.size() - 1)));
		holdPc = pc;
		repeat (5) begin
			@(negedge clk);
			checkValue("pc", pc, holdPc);
			checkValue("halted", 64'(halted), 64'd1);
			checkValue("store.valid", 64'(store.valid), 64'd0);
		end
		// Second run, all-zero word decodes as nothing known
		prog.delete();
		expStores.delete();
		gotStores.delete();
		prog.push_back(32'h0000_0000);
		loadProgram();
		runUntilHalt();
		checkValue("halted", 64'(halted), 64'd1);
		checkValue("illegalOp", 64'(illegalOp), 64'd1);
		assert (gotStores.size() == 0) else begin
			$display("The illegal-opcode run produced %0d stores", gotStores.size());
			otherErrors++;
		end
		$display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
